// ==== hw/m6502_pkg.sv ====
// Reduced 6502 core shared definitions: bus widths and the operation, mode and state encodings
`default_nettype none

package m6502_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 8;

   // Operation decoded from the opcode, unsupported opcodes map to NOP
   typedef enum logic [5:0] {
      CPU_OP_NOP,
      CPU_OP_LDA,
      CPU_OP_LDX,
      CPU_OP_LDY,
      CPU_OP_STA,
      CPU_OP_STX,
      CPU_OP_STY,
      CPU_OP_ADC,
      CPU_OP_SBC,
      CPU_OP_AND,
      CPU_OP_ORA,
      CPU_OP_EOR,
      CPU_OP_CMP,
      CPU_OP_INX,
      CPU_OP_INY,
      CPU_OP_DEX,
      CPU_OP_DEY,
      CPU_OP_TAX,
      CPU_OP_TAY,
      CPU_OP_TXA,
      CPU_OP_TYA,
      CPU_OP_CLC,
      CPU_OP_SEC,
      CPU_OP_CLV,
      CPU_OP_BRANCH,
      CPU_OP_JMP
   } cpu_op_t;

   typedef enum logic [1:0] {
      MODE_SINGLE,   // Opcode byte only
      MODE_IMM,
      MODE_ZP,
      MODE_ABS
   } addr_mode_t;

   typedef enum logic [3:0] {
      OP_PASS,
      OP_ADC,        // Also SBC, with in_b inverted
      OP_AND,
      OP_OR,
      OP_EOR,
      OP_CMP,
      OP_INC,
      OP_DEC,
      OP_SET_C,
      OP_CLR_C,
      OP_CLR_V
   } alu_op_t;

   typedef enum logic [2:0] {
      ST_VEC_LO,
      ST_VEC_HI,
      ST_FETCH,
      ST_OPER_LO,
      ST_OPER_HI,
      ST_MEM,
      ST_EXEC
   } seq_state_t;

endpackage

`default_nettype wire

// ==== hw/m6502_alu_if.sv ====
// Link between the 6502 sequencer and its ALU: operands and operation out, result and flags back
`timescale 1ns/1ps
`default_nettype none

interface m6502_alu_if;
   import m6502_pkg::*;

   logic              proceed;   // Flags commit at this edge
   alu_op_t           op;
   logic [DATA_W-1:0] in_a;
   logic [DATA_W-1:0] in_b;
   logic [DATA_W-1:0] result;    // Valid in the same cycle
   logic              flag_n;
   logic              flag_v;
   logic              flag_z;
   logic              flag_c;

   modport seq (output proceed, op, in_a, in_b,
                input  result, flag_n, flag_v, flag_z, flag_c);

   modport alu (input  proceed, op, in_a, in_b,
                output result, flag_n, flag_v, flag_z, flag_c);

endinterface

`default_nettype wire

// ==== hw/m6502_decoder.sv ====
// 6502 opcode decoder: splits aaabbbcc into an operation and an addressing mode
`timescale 1ns/1ps
`default_nettype none

module m6502_decoder (
   input  wire [m6502_pkg::DATA_W-1:0] opcode_i,
   output m6502_pkg::cpu_op_t          cpu_op_o,
   output m6502_pkg::addr_mode_t       addr_mode_o
);
   import m6502_pkg::*;

   logic [2:0] aaa;
   logic [2:0] bbb;
   logic [1:0] cc;
   addr_mode_t mode_even;   // Mode column for cc = 00 and 10
   addr_mode_t mode_odd;    // Mode column for cc = 01

   assign aaa = opcode_i[7:5];
   assign bbb = opcode_i[4:2];
   assign cc  = opcode_i[1:0];

   always_comb
   begin
      case (bbb)
         3'd0:    mode_even = MODE_IMM;
         3'd1:    mode_even = MODE_ZP;
         3'd3:    mode_even = MODE_ABS;
         default: mode_even = MODE_SINGLE;
      endcase
      case (bbb)
         3'd1:    mode_odd = MODE_ZP;
         3'd2:    mode_odd = MODE_IMM;
         3'd3:    mode_odd = MODE_ABS;
         default: mode_odd = MODE_SINGLE;
      endcase
   end

   always_comb
   begin
      cpu_op_o    = CPU_OP_NOP;
      addr_mode_o = MODE_SINGLE;
      case (cc)
         2'b00:
            if (bbb == 3'd4)
            begin
               cpu_op_o    = CPU_OP_BRANCH;
               addr_mode_o = MODE_IMM;   // Offset byte
            end
            else if (bbb == 3'd6)
            begin
               case (aaa)
                  3'd0:    cpu_op_o = CPU_OP_CLC;
                  3'd1:    cpu_op_o = CPU_OP_SEC;
                  3'd4:    cpu_op_o = CPU_OP_TYA;
                  3'd5:    cpu_op_o = CPU_OP_CLV;
                  default: cpu_op_o = CPU_OP_NOP;
               endcase
            end
            else
            begin
               case (aaa)
                  3'd2:
                     if (bbb == 3'd3)
                     begin
                        cpu_op_o    = CPU_OP_JMP;
                        addr_mode_o = MODE_ABS;
                     end
                  3'd4:
                     if (bbb == 3'd1 || bbb == 3'd3)
                     begin
                        cpu_op_o    = CPU_OP_STY;
                        addr_mode_o = mode_even;
                     end
                     else if (bbb == 3'd2)
                        cpu_op_o = CPU_OP_DEY;
                  3'd5:
                     if (bbb == 3'd2)
                        cpu_op_o = CPU_OP_TAY;
                     else if (mode_even != MODE_SINGLE)
                     begin
                        cpu_op_o    = CPU_OP_LDY;
                        addr_mode_o = mode_even;
                     end
                  3'd6:
                     if (bbb == 3'd2)
                        cpu_op_o = CPU_OP_INY;
                  3'd7:
                     if (bbb == 3'd2)
                        cpu_op_o = CPU_OP_INX;
                  default: cpu_op_o = CPU_OP_NOP;
               endcase
            end
         2'b01:
            // No STA immediate, indexed columns are not kept
            if (mode_odd != MODE_SINGLE && !(aaa == 3'd4 && bbb == 3'd2))
            begin
               addr_mode_o = mode_odd;
               case (aaa)
                  3'd0: cpu_op_o = CPU_OP_ORA;
                  3'd1: cpu_op_o = CPU_OP_AND;
                  3'd2: cpu_op_o = CPU_OP_EOR;
                  3'd3: cpu_op_o = CPU_OP_ADC;
                  3'd4: cpu_op_o = CPU_OP_STA;
                  3'd5: cpu_op_o = CPU_OP_LDA;
                  3'd6: cpu_op_o = CPU_OP_CMP;
                  3'd7: cpu_op_o = CPU_OP_SBC;
               endcase
            end
         2'b10:
            case (aaa)
               3'd4:
                  if (bbb == 3'd1 || bbb == 3'd3)
                  begin
                     cpu_op_o    = CPU_OP_STX;
                     addr_mode_o = mode_even;
                  end
                  else if (bbb == 3'd2)
                     cpu_op_o = CPU_OP_TXA;
               3'd5:
                  if (bbb == 3'd2)
                     cpu_op_o = CPU_OP_TAX;
                  else if (mode_even != MODE_SINGLE)
                  begin
                     cpu_op_o    = CPU_OP_LDX;
                     addr_mode_o = mode_even;
                  end
               3'd6:
                  if (bbb == 3'd2)
                     cpu_op_o = CPU_OP_DEX;
               default: cpu_op_o = CPU_OP_NOP;   // Shifts and rotates dropped
            endcase
         default: cpu_op_o = CPU_OP_NOP;
      endcase
   end

endmodule

`default_nettype wire

// ==== hw/m6502_alu.sv ====
// 6502 ALU: combinational result for each operation and the N, V, Z, C flag register
`timescale 1ns/1ps
`default_nettype none

module m6502_alu (
   input wire       clk,
   input wire       reset_n,
   m6502_alu_if.alu bus
);
   import m6502_pkg::*;

   logic [DATA_W:0]   sum;
   logic [DATA_W:0]   diff;
   logic [DATA_W-1:0] nz_val;
   logic              overflow;

   assign sum  = {1'b0, bus.in_a} + {1'b0, bus.in_b} + {{DATA_W{1'b0}}, bus.flag_c};
   assign diff = {1'b0, bus.in_a} + {1'b0, ~bus.in_b} + {{DATA_W{1'b0}}, 1'b1};

   // Both inputs share a sign that the sum does not
   assign overflow = (bus.in_a[DATA_W-1] == bus.in_b[DATA_W-1]) &&
                     (sum[DATA_W-1] != bus.in_a[DATA_W-1]);

   always_comb
   begin
      case (bus.op)
         OP_ADC:  bus.result = sum[DATA_W-1:0];
         OP_AND:  bus.result = bus.in_a & bus.in_b;
         OP_OR:   bus.result = bus.in_a | bus.in_b;
         OP_EOR:  bus.result = bus.in_a ^ bus.in_b;
         OP_INC:  bus.result = bus.in_a + DATA_W'(1);
         OP_DEC:  bus.result = bus.in_a - DATA_W'(1);
         default: bus.result = bus.in_a;   // PASS, CMP and flag ops
      endcase
   end

   assign nz_val = (bus.op == OP_CMP) ? diff[DATA_W-1:0] : bus.result;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         bus.flag_n <= 1'b0;
         bus.flag_v <= 1'b0;
         bus.flag_z <= 1'b0;
         bus.flag_c <= 1'b0;
      end
      else if (bus.proceed)
      begin
         case (bus.op)
            OP_SET_C: bus.flag_c <= 1'b1;
            OP_CLR_C: bus.flag_c <= 1'b0;
            OP_CLR_V: bus.flag_v <= 1'b0;
            default:
            begin
               bus.flag_n <= nz_val[DATA_W-1];
               bus.flag_z <= (nz_val == '0);
            end
         endcase
         if (bus.op == OP_ADC)
         begin
            bus.flag_c <= sum[DATA_W];
            bus.flag_v <= overflow;
         end
         if (bus.op == OP_CMP)
            bus.flag_c <= diff[DATA_W];   // Set when no borrow
      end
   end

endmodule

`default_nettype wire

// ==== hw/m6502_sequencer.sv ====
// 6502 sequencer: reset vector load, opcode and operand fetch, execute, A/X/Y/PC and bus
`timescale 1ns/1ps
`default_nettype none

module m6502_sequencer #(
   parameter logic [m6502_pkg::ADDR_W-1:0] RESET_VECTOR = 16'hfffc
) (
   input  wire                          clk,
   input  wire                          reset_n,
   input  wire [m6502_pkg::DATA_W-1:0]  rd_data_i,
   input  wire                          ready_i,
   input  wire m6502_pkg::cpu_op_t      cpu_op_i,
   input  wire m6502_pkg::addr_mode_t   addr_mode_i,
   output logic [m6502_pkg::DATA_W-1:0] opcode_o,
   output logic [m6502_pkg::ADDR_W-1:0] addr_o,
   output logic                         rd_req_o,
   output logic                         wr_en_o,
   output logic [m6502_pkg::DATA_W-1:0] wr_data_o,
   output logic                         sync_o,
   m6502_alu_if.seq                     alu
);
   import m6502_pkg::*;

   seq_state_t        state_q;
   logic              data_ph_q;   // Data cycle of the read issued the cycle before
   logic              boot_q;      // Idle cycle after reset
   logic [ADDR_W-1:0] pc_q;
   logic [DATA_W-1:0] opcode_q;
   logic [DATA_W-1:0] oper_lo_q;
   logic [DATA_W-1:0] oper_hi_q;
   logic [DATA_W-1:0] reg_a_q;
   logic [DATA_W-1:0] reg_x_q;
   logic [DATA_W-1:0] reg_y_q;
   logic [ADDR_W-1:0] eff_addr;
   logic [ADDR_W-1:0] pc_next;
   logic [1:0]        pc_step;
   logic              is_store;
   logic              flag_sel;
   logic              take_branch;

   // The opcode is decoded straight off the bus in its data cycle
   assign opcode_o = (state_q == ST_FETCH && data_ph_q) ? rd_data_i : opcode_q;

   assign is_store = cpu_op_i inside {CPU_OP_STA, CPU_OP_STX, CPU_OP_STY};
   assign eff_addr = (addr_mode_i == MODE_ABS) ? {oper_hi_q, oper_lo_q} :
                                                 {{(ADDR_W-DATA_W){1'b0}}, oper_lo_q};

   always_comb
   begin
      case (state_q)
         ST_VEC_LO:  addr_o = RESET_VECTOR;
         ST_VEC_HI:  addr_o = RESET_VECTOR + ADDR_W'(1);
         ST_FETCH:   addr_o = pc_q;
         ST_OPER_LO: addr_o = pc_q + ADDR_W'(1);
         ST_OPER_HI: addr_o = pc_q + ADDR_W'(2);
         default:    addr_o = eff_addr;
      endcase
   end

   assign rd_req_o = (state_q == ST_MEM) ? !is_store :
                     (state_q != ST_EXEC && !boot_q && !data_ph_q);
   assign wr_en_o  = (state_q == ST_MEM) && is_store;
   assign sync_o   = (state_q == ST_FETCH) && !data_ph_q && !boot_q;

   always_comb
   begin
      case (cpu_op_i)
         CPU_OP_STX: wr_data_o = reg_x_q;
         CPU_OP_STY: wr_data_o = reg_y_q;
         default:    wr_data_o = reg_a_q;
      endcase
   end

   // aaa[2:1] picks the flag, aaa[0] the value that takes the branch
   always_comb
   begin
      case (opcode_q[7:6])
         2'b00:   flag_sel = alu.flag_n;
         2'b01:   flag_sel = alu.flag_v;
         2'b10:   flag_sel = alu.flag_c;
         default: flag_sel = alu.flag_z;
      endcase
      take_branch = (flag_sel == opcode_q[5]);
   end

   always_comb
   begin
      case (addr_mode_i)
         MODE_SINGLE: pc_step = 2'd1;
         MODE_ABS:    pc_step = 2'd3;
         default:     pc_step = 2'd2;
      endcase
      pc_next = pc_q + ADDR_W'(pc_step);
      if (cpu_op_i == CPU_OP_BRANCH && take_branch)
         pc_next = pc_next + {{(ADDR_W-DATA_W){rd_data_i[DATA_W-1]}}, rd_data_i};
      else if (cpu_op_i == CPU_OP_JMP)
         pc_next = {rd_data_i, oper_lo_q};
   end

   // ALU steering, memory operand arrives on rd_data_i during EXEC
   always_comb
   begin
      alu.op   = OP_PASS;
      alu.in_a = reg_a_q;
      alu.in_b = rd_data_i;
      case (cpu_op_i)
         CPU_OP_LDA, CPU_OP_LDX, CPU_OP_LDY: alu.in_a = rd_data_i;
         CPU_OP_ADC: alu.op = OP_ADC;
         CPU_OP_SBC:
         begin
            alu.op   = OP_ADC;
            alu.in_b = ~rd_data_i;
         end
         CPU_OP_AND: alu.op = OP_AND;
         CPU_OP_ORA: alu.op = OP_OR;
         CPU_OP_EOR: alu.op = OP_EOR;
         CPU_OP_CMP: alu.op = OP_CMP;
         CPU_OP_INX, CPU_OP_DEX:
         begin
            alu.op   = (cpu_op_i == CPU_OP_INX) ? OP_INC : OP_DEC;
            alu.in_a = reg_x_q;
         end
         CPU_OP_INY, CPU_OP_DEY:
         begin
            alu.op   = (cpu_op_i == CPU_OP_INY) ? OP_INC : OP_DEC;
            alu.in_a = reg_y_q;
         end
         CPU_OP_TXA: alu.in_a = reg_x_q;
         CPU_OP_TYA: alu.in_a = reg_y_q;
         CPU_OP_CLC: alu.op = OP_CLR_C;
         CPU_OP_SEC: alu.op = OP_SET_C;
         CPU_OP_CLV: alu.op = OP_CLR_V;
         default:    alu.op = OP_PASS;
      endcase
      alu.proceed = (state_q == ST_EXEC) && ready_i &&
                    !(cpu_op_i inside {CPU_OP_NOP, CPU_OP_STA, CPU_OP_STX, CPU_OP_STY,
                                       CPU_OP_BRANCH, CPU_OP_JMP});
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state_q   <= ST_VEC_LO;
         data_ph_q <= 1'b0;
         boot_q    <= 1'b1;
         reg_a_q   <= '0;
         reg_x_q   <= '0;
         reg_y_q   <= '0;
      end
      else if (ready_i)
      begin
         boot_q <= 1'b0;
         if (!boot_q)
         begin
            data_ph_q <= 1'b0;
            case (state_q)
               ST_VEC_LO:
               begin
                  data_ph_q <= !data_ph_q;
                  if (data_ph_q)
                  begin
                     oper_lo_q <= rd_data_i;
                     state_q   <= ST_VEC_HI;
                  end
               end
               ST_VEC_HI:
               begin
                  data_ph_q <= !data_ph_q;
                  if (data_ph_q)
                  begin
                     pc_q    <= {rd_data_i, oper_lo_q};
                     state_q <= ST_FETCH;
                  end
               end
               ST_FETCH:
               begin
                  data_ph_q <= !data_ph_q;
                  if (data_ph_q)
                  begin
                     opcode_q <= rd_data_i;
                     state_q  <= (addr_mode_i == MODE_SINGLE) ? ST_EXEC : ST_OPER_LO;
                  end
               end
               ST_OPER_LO:
                  if (addr_mode_i == MODE_IMM)
                     state_q <= ST_EXEC;   // Operand is used in its data cycle
                  else
                  begin
                     data_ph_q <= !data_ph_q;
                     if (data_ph_q)
                     begin
                        oper_lo_q <= rd_data_i;
                        state_q   <= (addr_mode_i == MODE_ABS) ? ST_OPER_HI : ST_MEM;
                     end
                  end
               ST_OPER_HI:
                  if (cpu_op_i == CPU_OP_JMP)
                     state_q <= ST_EXEC;
                  else
                  begin
                     data_ph_q <= !data_ph_q;
                     if (data_ph_q)
                     begin
                        oper_hi_q <= rd_data_i;
                        state_q   <= ST_MEM;
                     end
                  end
               ST_MEM: state_q <= ST_EXEC;
               default:
               begin
                  pc_q    <= pc_next;
                  state_q <= ST_FETCH;
                  case (cpu_op_i)
                     CPU_OP_LDA, CPU_OP_ADC, CPU_OP_SBC, CPU_OP_AND,
                     CPU_OP_ORA, CPU_OP_EOR, CPU_OP_TXA, CPU_OP_TYA:
                        reg_a_q <= alu.result;
                     CPU_OP_LDX, CPU_OP_INX, CPU_OP_DEX, CPU_OP_TAX:
                        reg_x_q <= alu.result;
                     CPU_OP_LDY, CPU_OP_INY, CPU_OP_DEY, CPU_OP_TAY:
                        reg_y_q <= alu.result;
                     default: ;
                  endcase
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/m6502_cpu.sv ====
// Reduced 6502 CPU top: sequencer, opcode decoder and ALU on a plain memory bus
`timescale 1ns/1ps
`default_nettype none

module m6502_cpu #(
   parameter logic [m6502_pkg::ADDR_W-1:0] RESET_VECTOR = 16'hfffc
) (
   input  wire                         clk,
   input  wire                         reset_n,
   output wire [m6502_pkg::ADDR_W-1:0] addr_o,
   output wire                         rd_req_o,
   input  wire [m6502_pkg::DATA_W-1:0] rd_data_i,
   output wire                         wr_en_o,
   output wire [m6502_pkg::DATA_W-1:0] wr_data_o,
   input  wire                         ready_i,
   output wire                         sync_o
);
   import m6502_pkg::*;

   cpu_op_t           cpu_op;
   addr_mode_t        addr_mode;
   logic [DATA_W-1:0] opcode;

   m6502_alu_if alu_bus ();

   m6502_sequencer #(
      .RESET_VECTOR (RESET_VECTOR)
   ) u_sequencer (
      .clk         (clk),
      .reset_n     (reset_n),
      .rd_data_i   (rd_data_i),
      .ready_i     (ready_i),
      .cpu_op_i    (cpu_op),
      .addr_mode_i (addr_mode),
      .opcode_o    (opcode),
      .addr_o      (addr_o),
      .rd_req_o    (rd_req_o),
      .wr_en_o     (wr_en_o),
      .wr_data_o   (wr_data_o),
      .sync_o      (sync_o),
      .alu         (alu_bus)
   );

   m6502_decoder u_decoder (
      .opcode_i    (opcode),
      .cpu_op_o    (cpu_op),
      .addr_mode_o (addr_mode)
   );

   m6502_alu u_alu (
      .clk     (clk),
      .reset_n (reset_n),
      .bus     (alu_bus)
   );

endmodule

`default_nettype wire

// ==== test/tb_mem_model.sv ====
// Testbench memory: 64 KiB behind the 6502 bus, with preload port and random ready stalls
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
   input  wire         clk,
   input  wire         stall_en_i,
   input  wire         freeze_i,
   input  wire         fill_i,
   input  wire         load_en_i,
   input  wire  [15:0] load_addr_i,
   input  wire  [7:0]  load_data_i,
   input  wire  [15:0] addr_i,
   input  wire         rd_req_i,
   input  wire         wr_en_i,
   input  wire  [7:0]  wr_data_i,
   output logic [7:0]  rd_data_o,
   output logic        ready_o,
   output logic        wr_seen_o,
   output logic [15:0] wr_addr_o,
   output logic [7:0]  wr_byte_o
);

   logic [7:0]  mem [0:65535];
   integer      seed = 32'hb2ce;
   logic        rd_pend = 1'b0;
   logic [15:0] rd_addr_q = 16'h0000;
   logic        ready_nxt = 1'b0;

   initial
   begin
      rd_data_o = 8'h00;
      ready_o   = 1'b0;
      wr_seen_o = 1'b0;
      wr_addr_o = 16'h0000;
      wr_byte_o = 8'h00;
   end

   always @(posedge clk)
   begin
      if (fill_i)
      begin
         for (int i = 0; i < 65536; i++)
            mem[i] <= i[15:8] ^ i[7:0];   // Depends on the whole address
      end
      else if (load_en_i)
         mem[load_addr_i] <= load_data_i;
      if (wr_en_i && ready_o)
         mem[addr_i] <= wr_data_i;
      wr_seen_o <= wr_en_i && ready_o;
      wr_addr_o <= addr_i;
      wr_byte_o <= wr_data_i;
      rd_pend   <= rd_req_i && ready_o;
      if (rd_req_i && ready_o)
         rd_addr_q <= addr_i;
      ready_nxt <= freeze_i ? 1'b0 : (stall_en_i ? (($random(seed) & 3) != 0) : 1'b1);
   end

   // Data of an accepted read shows up in the following cycle and holds
   always @(negedge clk)
   begin
      if (rd_pend)
         rd_data_o <= mem[rd_addr_q];
      ready_o <= ready_nxt;
   end

endmodule

`default_nettype wire

// ==== test/tb_m6502_cpu.sv ====
// Testbench for the reduced 6502 core: runs the stim program and checks every bus write
`timescale 1ns/1ps
`default_nettype none

module tb_m6502_cpu;

   localparam int          CLK_PERIOD = 4;
   localparam int          TIMEOUT    = 1000;
   localparam logic [15:0] VEC_ADDR   = 16'hfffc;
   localparam string       STIM_FILE  = "test/m6502_stim.txt";

   logic        clk;
   logic        reset_n;
   logic        stall_en;
   logic        freeze;
   logic        fill;
   logic        load_en;
   logic [15:0] load_addr;
   logic [7:0]  load_data;
   wire  [15:0] addr;
   wire         rd_req;
   wire  [7:0]  rd_data;
   wire         wr_en;
   wire  [7:0]  wr_data;
   wire         ready;
   wire         sync;
   wire         wr_seen;
   wire  [15:0] wr_addr;
   wire  [7:0]  wr_byte;

   int          errors    = 0;
   int          tests_ok  = 0;
   int          tests_bad = 0;
   logic        aborted   = 1'b0;
   logic [15:0] img_addr_q[$];
   logic [7:0]  img_data_q[$];
   string       test_name_q[$];
   logic [15:0] exp_addr_q[$];
   logic [7:0]  exp_data_q[$];
   int          exp_test_q[$];

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   m6502_cpu #(
      .RESET_VECTOR (VEC_ADDR)
   ) DUT (
      .clk       (clk),
      .reset_n   (reset_n),
      .addr_o    (addr),
      .rd_req_o  (rd_req),
      .rd_data_i (rd_data),
      .wr_en_o   (wr_en),
      .wr_data_o (wr_data),
      .ready_i   (ready),
      .sync_o    (sync)
   );

   tb_mem_model mem_model (
      .clk         (clk),
      .stall_en_i  (stall_en),
      .freeze_i    (freeze),
      .fill_i      (fill),
      .load_en_i   (load_en),
      .load_addr_i (load_addr),
      .load_data_i (load_data),
      .addr_i      (addr),
      .rd_req_i    (rd_req),
      .wr_en_i     (wr_en),
      .wr_data_i   (wr_data),
      .rd_data_o   (rd_data),
      .ready_o     (ready),
      .wr_seen_o   (wr_seen),
      .wr_addr_o   (wr_addr),
      .wr_byte_o   (wr_byte)
   );

   // Memory contents as the stim file leaves them, over the fill pattern
   function automatic logic [7:0] image_byte(input logic [15:0] a);
      logic [7:0] d;
      d = a[15:8] ^ a[7:0];
      foreach (img_addr_q[i])
         if (img_addr_q[i] == a)
            d = img_data_q[i];
      return d;
   endfunction

   task automatic read_stim();
      integer      fd;
      integer      rc;
      string       tok;
      string       text;
      logic [15:0] a;
      logic [7:0]  d;
      logic        done;
      fd   = $fopen(STIM_FILE, "r");
      done = 1'b0;
      if (fd == 0)
      begin
         $display("Could not open stimulus file %s", STIM_FILE);
         aborted = 1'b1;
         done    = 1'b1;
      end
      while (!done)
      begin
         rc = $fscanf(fd, "%s", tok);
         if (rc != 1 || tok == "E")
            done = 1'b1;
         else if (tok == "#")
            rc = $fgets(text, fd);
         else if (tok == "M")
         begin
            rc = $fscanf(fd, "%h %s", a, text);
            for (int i = 0; i < text.len() / 2; i++)
            begin
               img_addr_q.push_back(a + 16'(i));
               img_data_q.push_back(8'(text.substr(2 * i, 2 * i + 1).atohex()));
            end
         end
         else if (tok == "T")
         begin
            rc = $fscanf(fd, "%s", text);
            test_name_q.push_back(text);
         end
         else if (tok == "W")
         begin
            rc = $fscanf(fd, "%h %h", a, d);
            exp_addr_q.push_back(a);
            exp_data_q.push_back(d);
            exp_test_q.push_back(test_name_q.size() - 1);
         end
      end
      if (fd != 0)
         $fclose(fd);
   endtask

   task automatic load_memory();
      @(negedge clk);
      fill = 1'b1;
      @(negedge clk);
      fill = 1'b0;
      foreach (img_addr_q[i])
      begin
         load_en   = 1'b1;
         load_addr = img_addr_q[i];
         load_data = img_data_q[i];
         @(negedge clk);
      end
      load_en = 1'b0;
   endtask

   task automatic wait_sync(output logic got);
      int cnt;
      got = 1'b0;
      cnt = 0;
      while (!got && cnt < TIMEOUT)
      begin
         @(negedge clk);
         cnt++;
         if (sync)
            got = 1'b1;
      end
   endtask

   task automatic wait_write(output logic got, output logic [15:0] a, output logic [7:0] d);
      int cnt;
      got = 1'b0;
      cnt = 0;
      a   = '0;
      d   = '0;
      while (!got && cnt < TIMEOUT)
      begin
         @(negedge clk);
         cnt++;
         if (wr_seen)
         begin
            got = 1'b1;
            a   = wr_addr;
            d   = wr_byte;
         end
      end
   endtask

   task automatic run_pass(input logic stalls, input string label);
      int          wi;
      int          err_mark;
      logic        got;
      logic [15:0] start;
      logic [15:0] wa;
      logic [7:0]  wd;
      @(negedge clk);
      freeze = 1'b1;   // Core holds while the image goes in
      load_memory();
      start    = {image_byte(VEC_ADDR + 16'd1), image_byte(VEC_ADDR)};
      err_mark = errors;
      reset_n  = 1'b0;
      freeze   = 1'b0;
      stall_en = stalls;
      // Last sample falls in the idle cycle as reset_n rises
      repeat (3)
      begin
         @(negedge clk);
         assert (!rd_req && !wr_en && !sync)
         else
         begin
            $display("ERR %0t: rd_req=%b wr_en=%b sync=%b in reset, expected all 0",
                     $time, rd_req, wr_en, sync);
            errors++;
         end
      end
      reset_n  = 1'b1;
      wait_sync(got);
      if (!got)
      begin
         $display("Timeout in %s pass: no opcode fetch after reset", label);
         aborted = 1'b1;
         return;
      end
      assert (addr == start)
      else
      begin
         $display("ERR %0t: first opcode fetch at %h, expected %h", $time, addr, start);
         errors++;
      end
      wi = 0;
      foreach (test_name_q[t])
      begin
         if (t != 0)
            err_mark = errors;
         while (wi < exp_test_q.size() && exp_test_q[wi] == t)
         begin
            wait_write(got, wa, wd);
            if (!got)
            begin
               $display("Timeout in %s pass: write %0d of test %s never arrived",
                        label, wi, test_name_q[t]);
               aborted = 1'b1;
               return;
            end
            assert (wa == exp_addr_q[wi] && wd == exp_data_q[wi])
            else
            begin
               $display("ERR %0t: write %h=%h, expected %h=%h", $time, wa, wd,
                        exp_addr_q[wi], exp_data_q[wi]);
               errors++;
            end
            wi++;
         end
         if (errors == err_mark)
            tests_ok++;
         else
            tests_bad++;
         $display("%s %s: %s", label, test_name_q[t], (errors == err_mark) ? "ok" : "bad");
      end
   endtask

   initial
   begin
      reset_n   = 1'b1;
      stall_en  = 1'b0;
      freeze    = 1'b1;
      fill      = 1'b0;
      load_en   = 1'b0;
      load_addr = 16'h0000;
      load_data = 8'h00;
      read_stim();
      if (!aborted)
         run_pass(1'b0, "plain");
      if (!aborted)
         run_pass(1'b1, "stall");
      $display("Tests ok %0d, bad %0d, errors %0d", tests_ok, tests_bad, errors);
      if (errors == 0 && tests_bad == 0 && !aborted)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== m6502_cpu.f ====
hw/m6502_pkg.sv
hw/m6502_alu_if.sv
hw/m6502_decoder.sv
hw/m6502_alu.sv
hw/m6502_sequencer.sv
hw/m6502_cpu.sv
test/tb_mem_model.sv
test/tb_m6502_cpu.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_m6502_cpu
FILELIST  := m6502_cpu.f
OBJ_DIR   := obj_dir
PASS_MSG  := TB PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) hw/*.sv test/*.sv
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/m6502_stim.txt ====
# M addr bytes : preload memory from addr, bytes as one hex string
# T name : open a test, W addr data : next expected write, E : end
M 0200 a95a8510
M 0204 a2338e0003a0c48411
M 020d a5408d0103a6418612
M 0216 ac00048c0203ad01048513
M 0221 ae02048e0303a4428414
M 022b 18a9506950852038a9ff69018521
M 0239 6540852238a910e9018523
M 0244 18a910e901852438a980e9018525
M 0252 a9f0293c85260905852749ff852825418529
M 0264 a211a940c940f002a2128630
M 0270 a221c941b002a2228631
M 027a a231c9413002a2328632
M 0284 a241c9309002a2428633
M 028e 18a9506950a2517002a2528634
M 029b b8a2615002a2628635
M 02a4 a2711002a2728636
M 02ac a2811002a2828637
M 02b4 a291d002a2928638
M 02bc a2fee8e88650a00188888451
M 02c8 988552a93caae88653a8888454
M 02d5 8a85554cdd028556a9e785574ce102
M 0040 7788ef
M 0400 99abcd
M fffc 0002
T reset_vector
W 0010 5a
T loads_stores
W 0300 33
W 0011 c4
W 0301 77
W 0012 88
W 0302 99
W 0013 ab
W 0303 cd
W 0014 ef
T alu_ops
W 0020 a0
W 0021 01
W 0022 79
W 0023 0f
W 0024 0e
W 0025 7f
W 0026 30
W 0027 35
W 0028 ca
W 0029 88
T compare_branch
W 0030 11
W 0031 22
W 0032 31
W 0033 42
W 0034 51
W 0035 61
W 0036 71
W 0037 82
W 0038 91
T regs_jmp
W 0050 00
W 0051 ff
W 0052 ff
W 0053 3d
W 0054 3b
W 0055 3d
W 0057 e7
E
